// ==== trace_pkg.sv ====
// Trace bus widths, debug group array type, select-control struct and rotate enum
package trace_pkg;

   // ----------------------------------------
   // Bus format
   // ----------------------------------------
   localparam int trace_width = 32;
   localparam int ctrl_width  = 4;
   localparam int num_groups  = 16;

   // Byte lanes of one trace word
   localparam int byte_width  = 8;
   localparam int num_bytes   = trace_width / byte_width;

   // ----------------------------------------
   // Types
   // ----------------------------------------
   typedef logic [trace_width-1:0] trace_word_t;
   typedef logic [ctrl_width-1:0]  trace_ctrl_t;

   // Index g holds group g
   typedef trace_word_t [num_groups-1:0] dbg_groups_t;

   // Left rotation of the selected group, in whole bytes
   typedef enum logic [1:0] {
      rot_0  = 2'd0,
      rot_8  = 2'd1,
      rot_16 = 2'd2,
      rot_24 = 2'd3
   } rot_t;

   // Select controls, 11 bits, group_sel in the top bits
   typedef struct packed {
      logic [3:0] group_sel;
      rot_t       rot;
      // Bit i takes byte i of the rotated group
      logic [3:0] byte_sel;
      // Clear drives a zero control field
      logic       ctrl_pass;
   } mux_ctrls_t;

endpackage

// ==== trace_mux16.sv ====
// Debug group selector, byte rotator, byte merger and core-trace control passer
`timescale 1ns/1ps

module trace_mux16 (
   input  trace_pkg::mux_ctrls_t  mux_ctrls,
   input  trace_pkg::dbg_groups_t groups,
   input  trace_pkg::trace_word_t bus_in,
   input  trace_pkg::trace_ctrl_t ctrls_in,
   output trace_pkg::trace_word_t bus_out,
   output trace_pkg::trace_ctrl_t ctrls_out
);

   trace_pkg::trace_word_t sel_word;
   trace_pkg::trace_word_t rot_word;

   // ----------------------------------------
   // Group select
   // ----------------------------------------
   assign sel_word = groups[mux_ctrls.group_sel];

   // ----------------------------------------
   // Byte rotation
   // ----------------------------------------
   // Rotate left, so the top byte wraps round to byte 0
   always_comb begin
      case (mux_ctrls.rot)
         trace_pkg::rot_0: begin
            rot_word = sel_word;
         end
         trace_pkg::rot_8: begin
            rot_word = {sel_word[23:0], sel_word[31:24]};
         end
         trace_pkg::rot_16: begin
            rot_word = {sel_word[15:0], sel_word[31:16]};
         end
         trace_pkg::rot_24: begin
            rot_word = {sel_word[7:0], sel_word[31:8]};
         end
         default: begin
            rot_word = sel_word;
         end
      endcase
   end

   // ----------------------------------------
   // Byte merge into the incoming bus
   // ----------------------------------------
   always_comb begin
      for (int i = 0; i < trace_pkg::num_bytes; i++) begin
         if (mux_ctrls.byte_sel[i]) begin
            bus_out[i*trace_pkg::byte_width +: trace_pkg::byte_width] =
               rot_word[i*trace_pkg::byte_width +: trace_pkg::byte_width];
         end else begin
            // Untaken lanes carry the upstream unit's bytes
            bus_out[i*trace_pkg::byte_width +: trace_pkg::byte_width] =
               bus_in[i*trace_pkg::byte_width +: trace_pkg::byte_width];
         end
      end
   end

   // ----------------------------------------
   // Core-trace control field
   // ----------------------------------------
   // Forwarded or zeroed, never merged
   assign ctrls_out = mux_ctrls.ctrl_pass ? ctrls_in : '0;

endmodule

// ==== trace_dbg_stage.sv ====
// Unit debug stage with enable register, gated select and output registers, and checks
`timescale 1ns/1ps

module trace_dbg_stage (
   input  logic                   nclk,
   input  logic                   rst_n,
   input  logic                   trace_enable,
   input  trace_pkg::mux_ctrls_t  mux_ctrls,
   input  trace_pkg::dbg_groups_t groups,
   input  trace_pkg::trace_word_t bus_in,
   input  trace_pkg::trace_ctrl_t ctrls_in,
   output trace_pkg::trace_word_t bus_out,
   output trace_pkg::trace_ctrl_t ctrls_out
);

   logic                   enable_q;
   trace_pkg::mux_ctrls_t  ctrls_q;
   trace_pkg::trace_word_t bus_d;
   trace_pkg::trace_ctrl_t ctrls_d;

   // ----------------------------------------
   // Select logic
   // ----------------------------------------
   trace_mux16 dbg_mux (
      .mux_ctrls (ctrls_q),
      .groups    (groups),
      .bus_in    (bus_in),
      .ctrls_in  (ctrls_in),
      .bus_out   (bus_d),
      .ctrls_out (ctrls_d)
   );

   // ----------------------------------------
   // Registers
   // ----------------------------------------
   // Enable is sampled every edge and gates everything else
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         enable_q <= 1'b0;
      end else begin
         enable_q <= trace_enable;
      end
   end

   // New select only takes effect a cycle after enable is seen
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         ctrls_q <= '0;
      end else if (enable_q) begin
         ctrls_q <= mux_ctrls;
      end
   end

   // Output stage toward the next unit, held while disabled
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         bus_out   <= '0;
         ctrls_out <= '0;
      end else if (enable_q) begin
         bus_out   <= bus_d;
         ctrls_out <= ctrls_d;
      end
   end

   // ----------------------------------------
   // Assertions
   // ----------------------------------------
   // A disabled stage must not move its select or output registers
   property p_hold_when_disabled;
      @(posedge nclk)
         (rst_n && !enable_q) |=> ($stable(ctrls_q) && $stable(bus_out) && $stable(ctrls_out));
   endproperty

   a_hold_when_disabled: assert property (p_hold_when_disabled)
      else $error("stage registers changed while enable_q was low");

   // Once out of reset the trace bus stays fully defined
   property p_bus_known;
      @(posedge nclk)
         rst_n |=> !$isunknown(bus_out);
   endproperty

   a_bus_known: assert property (p_bus_known)
      else $error("bus_out carries unknown bits after reset");

endmodule

// ==== trace_top.sv ====
// Two-stage trace path, instruction-side stage feeding the execution-side stage
`timescale 1ns/1ps

module trace_top (
   input  logic                   nclk,
   input  logic                   rst_n,

   // Instruction-side unit
   input  logic                   iu_trace_enable,
   input  trace_pkg::mux_ctrls_t  iu_mux_ctrls,
   input  trace_pkg::dbg_groups_t iu_groups,

   // Execution-side unit
   input  logic                   xu_trace_enable,
   input  trace_pkg::mux_ctrls_t  xu_mux_ctrls,
   input  trace_pkg::dbg_groups_t xu_groups,

   // Trace path in and out
   input  trace_pkg::trace_word_t debug_bus_in,
   input  trace_pkg::trace_ctrl_t coretrace_ctrls_in,
   output trace_pkg::trace_word_t debug_bus_out,
   output trace_pkg::trace_ctrl_t coretrace_ctrls_out
);

   // Link between the two stages
   trace_pkg::trace_word_t iu_bus;
   trace_pkg::trace_ctrl_t iu_ctrls;

   // ----------------------------------------
   // Instruction-side stage, first on the bus
   // ----------------------------------------
   trace_dbg_stage iu_stage (
      .nclk         (nclk),
      .rst_n        (rst_n),
      .trace_enable (iu_trace_enable),
      .mux_ctrls    (iu_mux_ctrls),
      .groups       (iu_groups),
      .bus_in       (debug_bus_in),
      .ctrls_in     (coretrace_ctrls_in),
      .bus_out      (iu_bus),
      .ctrls_out    (iu_ctrls)
   );

   // ----------------------------------------
   // Execution-side stage, drives the outputs
   // ----------------------------------------
   // Its taken bytes override whatever iu placed in the same lane
   trace_dbg_stage xu_stage (
      .nclk         (nclk),
      .rst_n        (rst_n),
      .trace_enable (xu_trace_enable),
      .mux_ctrls    (xu_mux_ctrls),
      .groups       (xu_groups),
      .bus_in       (iu_bus),
      .ctrls_in     (iu_ctrls),
      .bus_out      (debug_bus_out),
      .ctrls_out    (coretrace_ctrls_out)
   );

endmodule

// ==== trace_tb.sv ====
// Testbench for the two-stage trace path: pattern file stimulus, output checks, watchdog
`timescale 1ns/1ps

module trace_tb;

   localparam int num_steps   = 26;
   localparam int rec_words   = 10;
   localparam int step_cycles = 6;
   localparam int limit_cycles = num_steps * step_cycles + 40;

   logic                   nclk;
   logic                   rst_n;
   logic                   iu_trace_enable;
   trace_pkg::mux_ctrls_t  iu_mux_ctrls;
   trace_pkg::dbg_groups_t iu_groups;
   logic                   xu_trace_enable;
   trace_pkg::mux_ctrls_t  xu_mux_ctrls;
   trace_pkg::dbg_groups_t xu_groups;
   trace_pkg::trace_word_t debug_bus_in;
   trace_pkg::trace_ctrl_t coretrace_ctrls_in;
   trace_pkg::trace_word_t debug_bus_out;
   trace_pkg::trace_ctrl_t coretrace_ctrls_out;

   // Ten words per step, laid out as the columns of the pattern file
   logic [31:0] pattern_mem [0:num_steps*rec_words-1];

   trace_top uut (
      .nclk                (nclk),
      .rst_n               (rst_n),
      .iu_trace_enable     (iu_trace_enable),
      .iu_mux_ctrls        (iu_mux_ctrls),
      .iu_groups           (iu_groups),
      .xu_trace_enable     (xu_trace_enable),
      .xu_mux_ctrls        (xu_mux_ctrls),
      .xu_groups           (xu_groups),
      .debug_bus_in        (debug_bus_in),
      .coretrace_ctrls_in  (coretrace_ctrls_in),
      .debug_bus_out       (debug_bus_out),
      .coretrace_ctrls_out (coretrace_ctrls_out)
   );

   // ----------------------------------------
   // Clock and watchdog
   // ----------------------------------------
   initial begin
      nclk = 1'b0;
      forever #10 nclk = ~nclk;
   end

   initial begin
      repeat (limit_cycles) @(posedge nclk);
      $display("Timeout: the run did not complete within %0d clock cycles", limit_cycles);
      $display("Finished with errors");
      $fatal(1, "watchdog expired");
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   // Group g is the base word plus g in every byte
   function automatic trace_pkg::dbg_groups_t build_groups(input trace_pkg::trace_word_t base);
      trace_pkg::dbg_groups_t grp;
      for (int g = 0; g < trace_pkg::num_groups; g++) begin
         grp[g] = base + g * 32'h0101_0101;
      end
      return grp;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic apply_step(input int s);
      int b;
      b = s * rec_words;
      @(posedge nclk);
      iu_trace_enable    <= pattern_mem[b][0];
      iu_mux_ctrls       <= trace_pkg::mux_ctrls_t'(pattern_mem[b+1][10:0]);
      iu_groups          <= build_groups(pattern_mem[b+2]);
      xu_trace_enable    <= pattern_mem[b+3][0];
      xu_mux_ctrls       <= trace_pkg::mux_ctrls_t'(pattern_mem[b+4][10:0]);
      xu_groups          <= build_groups(pattern_mem[b+5]);
      debug_bus_in       <= pattern_mem[b+6];
      coretrace_ctrls_in <= pattern_mem[b+7][3:0];
   endtask

   // Sampled on the falling edge, away from register updates
   task automatic check_step(input int s);
      int                     b;
      trace_pkg::trace_word_t exp_bus;
      trace_pkg::trace_ctrl_t exp_ctrl;
      b = s * rec_words;
      exp_bus  = pattern_mem[b+8];
      exp_ctrl = pattern_mem[b+9][3:0];
      @(negedge nclk);
      assert (debug_bus_out === exp_bus) else begin
         stop_run($sformatf("[FAIL] %0d ns: step %0d debug_bus_out expected %h, got %h",
                            $time, s, exp_bus, debug_bus_out));
      end
      assert (coretrace_ctrls_out === exp_ctrl) else begin
         stop_run($sformatf("[FAIL] %0d ns: step %0d coretrace_ctrls_out expected %h, got %h",
                            $time, s, exp_ctrl, coretrace_ctrls_out));
      end
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      int b;
      rst_n              = 1'b0;
      iu_trace_enable    = 1'b0;
      iu_mux_ctrls       = '0;
      iu_groups          = '0;
      xu_trace_enable    = 1'b0;
      xu_mux_ctrls       = '0;
      xu_groups          = '0;
      debug_bus_in       = '0;
      coretrace_ctrls_in = '0;

      $readmemh("trace_patterns.txt", pattern_mem);
      for (int s = 0; s < num_steps; s++) begin
         b = s * rec_words;
         if ((pattern_mem[b] !== 32'd0 && pattern_mem[b] !== 32'd1) ||
             (pattern_mem[b+3] !== 32'd0 && pattern_mem[b+3] !== 32'd1)) begin
            stop_run($sformatf("Pattern file is malformed: step %0d has a bad enable field", s));
         end
      end

      repeat (10) @(posedge nclk);
      rst_n <= 1'b1;

      for (int s = 0; s < num_steps; s++) begin
         apply_step(s);
         repeat (step_cycles - 1) @(posedge nclk);
         check_step(s);
      end

      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== trace_patterns.txt ====
// Columns: iu_en iu_ctrls iu_base xu_en xu_ctrls xu_base bus_in ctrl_in exp_bus exp_ctrl
// ctrls = {group_sel[3:0], rot[1:0], byte_sel[3:0], ctrl_pass}, group g = base + g*01010101

// ----------------------------------------
// Reset, no stage enabled yet
// ----------------------------------------
0 19f 10203040 0 001 a0b0c0d0 55667788 5 00000000 0
0 19f 10203040 0 001 a0b0c0d0 89abcdef f 00000000 0

// ----------------------------------------
// Group select and rotation in iu, xu passes the bus
// ----------------------------------------
// Group 3, rot 0
1 19f 10203040 1 001 a0b0c0d0 55667788 5 13233343 5
// Group 3, rot 8
1 1bf 10203040 1 001 a0b0c0d0 55667788 a 23334313 a
// Group 7, rot 16
1 3df 10203040 1 001 a0b0c0d0 55667788 3 37471727 3
// Group 12, rot 24
1 67f 10203040 1 001 a0b0c0d0 55667788 c 4c1c2c3c c
// Group 15 of a new base, rot 0
1 79f 01020304 1 001 a0b0c0d0 0badf00d 6 10111213 6

// ----------------------------------------
// Byte merging across both stages
// ----------------------------------------
// iu bytes 1..0, xu bytes 2..1, byte 3 from bus_in
1 107 10203040 1 28d a0b0c0d0 55667788 9 55b5c542 9
// iu bytes 3..2 rot 8, xu byte 0 rot 16, byte 1 from bus_in
1 0b9 10203040 1 243 a0b0c0d0 01234567 e 213145b4 e
// Both take all bytes, xu wins
1 01f 10203040 1 4ff a0b0c0d0 01234567 1 d9a9b9c9 1
// iu bytes 2 and 0, xu byte 1 rot 8, byte 3 from bus_in
1 30b 10203040 1 525 a0b0c0d0 deadbeef 7 de26da46 7

// ----------------------------------------
// Control field passing
// ----------------------------------------
1 30a 10203040 1 525 a0b0c0d0 deadbeef 7 de26da46 0
1 30b 10203040 1 524 a0b0c0d0 deadbeef 7 de26da46 0
1 30a 10203040 1 524 a0b0c0d0 deadbeef f de26da46 0
1 30b 10203040 1 525 a0b0c0d0 deadbeef b de26da46 b

// ----------------------------------------
// Enable gating, xu stage
// ----------------------------------------
1 30b 10203040 0 525 a0b0c0d0 deadbeef b de26da46 b
1 19f 10203040 0 001 01020304 11111111 2 de26da46 b
1 1bf 10203040 0 001 01020304 22222222 4 de26da46 b
1 1bf 10203040 1 001 01020304 22222222 4 23334313 4

// ----------------------------------------
// Enable gating, iu stage
// ----------------------------------------
0 1bf 10203040 1 001 01020304 22222222 4 23334313 4
0 67f a0a0a0a0 1 001 01020304 33333333 8 23334313 4
0 67f 01020304 1 001 01020304 44444444 1 23334313 4
1 67f 01020304 1 001 01020304 44444444 1 100d0e0f 1

// ----------------------------------------
// Both stages off, new data, both back on
// ----------------------------------------
0 67f 01020304 0 001 01020304 44444444 1 100d0e0f 1
0 107 10203040 0 28d a0b0c0d0 55667788 9 100d0e0f 1
1 107 10203040 1 28d a0b0c0d0 55667788 9 55b5c542 9

// ==== sim.f ====
trace_pkg.sv
trace_mux16.sv
trace_dbg_stage.sv
trace_top.sv
trace_tb.sv
